// File: include/mds_config.svh
//////////////////////////////
// build switches for the multiply/divide/shift unit
// multiplier and divider enables, shift mode
//////////////////////////////
`ifndef MDS_CONFIG_SVH
`define MDS_CONFIG_SVH

// 1 builds the shift-add multiplier
// 0 makes every multiply op answer zero
`define MDS_ENABLE_MUL 1

// same switch for the restoring divider
`define MDS_ENABLE_DIV 1

// 1 selects the barrel path, any count done in one step
// 0 shifts one bit per cycle
`define MDS_SINGLE_CYCLE_SHIFT 0

`endif

// File: design/mds_pkg.sv
//////////////////////////////
// shared types for the multiply/divide/shift unit
// opcodes, shift kinds, request and operand structs
//////////////////////////////
`default_nettype none

package mds_pkg;

	typedef logic [31:0] word_t;	// every data word

	typedef enum logic [3:0] {
		OP_SLL, OP_SRL, OP_SRA,
		OP_MUL, OP_MULH, OP_MULS, OP_MULSH,
		OP_DIV, OP_REM
	} mds_op_e;

	typedef enum logic [1:0] {
		SHIFT_LL, SHIFT_RL, SHIFT_RA
	} mds_shift_e;

	// request as presented by the core
	typedef struct packed {
		mds_op_e op;
		word_t   a;
		word_t   b;
	} mds_req_t;

	// operands latched at acceptance, shared by the engines
	typedef struct packed {
		word_t a;
		word_t b;
	} mds_operands_t;

endpackage

`default_nettype wire

// File: design/mds_shifter.sv
//////////////////////////////
// iterative shifter, one bit per cycle
// optional single-cycle barrel path
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "mds_config.svh"

module mds_shifter import mds_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          start,
	input  mds_shift_e    kind,
	input  mds_operands_t operands,
	output logic          done,
	output word_t         result
);
	mds_shift_e kind_r;
	logic [4:0] count;	// bits still to shift
	logic       busy;
	logic [4:0] shamt;
	word_t      barrel;
	word_t      step;

	assign shamt = operands.b[4:0];

	always_comb begin
		case (kind)
			SHIFT_RL: barrel = operands.a >> shamt;
			SHIFT_RA: barrel = word_t'($signed(operands.a) >>> shamt);
			default:  barrel = operands.a << shamt;
		endcase
	end

	always_comb begin
		case (kind_r)
			SHIFT_RL: step = {1'b0, result[31:1]};
			SHIFT_RA: step = {result[31], result[31:1]};	// repeat sign bit
			default:  step = {result[30:0], 1'b0};
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				count <= shamt;
				if ((`MDS_SINGLE_CYCLE_SHIFT != 0) || (shamt == 5'd0)) begin
					done <= 1'b1;	// nothing left to iterate
				end else begin
					busy <= 1'b1;
				end
			end else if (busy) begin
				count <= count - 5'd1;
				if (count == 5'd1) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			kind_r <= kind;
			result <= (`MDS_SINGLE_CYCLE_SHIFT != 0) ? barrel : operands.a;
		end else if (busy) begin
			result <= step;
		end
	end

	// the sequencer must wait for done before the next start
	start_while_busy: assert property (@(posedge clock) disable iff (reset) start |-> !busy)
		else $error("shifter started while busy");

endmodule

`default_nettype wire

// File: design/mds_multiplier.sv
//////////////////////////////
// 32-step shift-add multiplier
// signed or unsigned, low or high word
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mds_multiplier import mds_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          start,
	input  logic          signed_ops,
	input  logic          high_word,
	input  mds_operands_t operands,
	output logic          done,
	output word_t         result
);
	logic [63:0] acc;	// running product
	logic [63:0] mcand;	// extended a, shifted left each step
	word_t       mplier;	// b, consumed from the lsb
	logic [4:0]  bit_idx;
	logic        busy;
	logic        signed_r;
	logic        high_r;
	logic        last;
	logic [63:0] addend;
	logic [63:0] acc_next;

	assign last = (bit_idx == 5'd31);

	always_comb begin
		addend = '0;
		if (mplier[0]) begin
			// bit 31 of a signed multiplier weighs -2^31
			addend = (last && signed_r) ? -mcand : mcand;
		end
		acc_next = acc + addend;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			bit_idx <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				bit_idx <= '0;
			end else if (busy) begin
				bit_idx <= bit_idx + 5'd1;
				if (last) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			acc      <= '0;
			mcand    <= signed_ops ? {{32{operands.a[31]}}, operands.a} : {32'b0, operands.a};
			mplier   <= operands.b;
			signed_r <= signed_ops;
			high_r   <= high_word;
		end else if (busy) begin
			acc    <= acc_next;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
			if (last) begin
				result <= high_r ? acc_next[63:32] : acc_next[31:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/mds_divider.sv
//////////////////////////////
// 32-step restoring divider, signed
// sign fix-up, zero divisor and overflow rules
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mds_divider import mds_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          start,
	input  logic          want_rem,
	input  mds_operands_t operands,
	output logic          done,
	output word_t         result
);
	word_t       a_r;	// original dividend, for the zero divisor case
	word_t       quo;	// dividend bits out, quotient bits in
	word_t       rem;	// partial remainder
	word_t       divisor;	// magnitude of b
	logic [4:0]  bit_idx;
	logic        busy;
	logic        rem_r;
	logic        div_zero;
	logic        ovf;
	logic        q_neg;
	logic        r_neg;
	logic        last;
	word_t       mag_a;
	word_t       mag_b;
	word_t       trial;
	logic [32:0] diff;
	logic        fits;
	word_t       rem_next;
	word_t       quo_next;
	word_t       fixed_q;
	word_t       fixed_r;
	word_t       final_val;

	assign mag_a = operands.a[31] ? -operands.a : operands.a;	// -2^31 stays 2^31 unsigned
	assign mag_b = operands.b[31] ? -operands.b : operands.b;
	assign last  = (bit_idx == 5'd31);

	// one restoring step
	assign trial    = {rem[30:0], quo[31]};
	assign diff     = {1'b0, trial} - {1'b0, divisor};
	assign fits     = !diff[32];
	assign rem_next = fits ? diff[31:0] : trial;
	assign quo_next = {quo[30:0], fits};

	assign fixed_q = q_neg ? -quo_next : quo_next;
	assign fixed_r = r_neg ? -rem_next : rem_next;

	always_comb begin
		if (div_zero) begin
			final_val = rem_r ? a_r : '1;
		end else if (ovf) begin
			final_val = rem_r ? '0 : 32'h8000_0000;
		end else begin
			final_val = rem_r ? fixed_r : fixed_q;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			bit_idx <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				bit_idx <= '0;
			end else if (busy) begin
				bit_idx <= bit_idx + 5'd1;
				if (last) begin
					busy <= 1'b0;
					done <= 1'b1;	// special cases take the full run too
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			a_r      <= operands.a;
			quo      <= mag_a;
			rem      <= '0;
			divisor  <= mag_b;
			rem_r    <= want_rem;
			div_zero <= (operands.b == '0);
			ovf      <= (operands.a == 32'h8000_0000) && (operands.b == '1);
			q_neg    <= operands.a[31] ^ operands.b[31];
			r_neg    <= operands.a[31];	// remainder follows the dividend
		end else if (busy) begin
			quo <= quo_next;
			rem <= rem_next;
			if (last) begin
				result <= final_val;
			end
		end
	end

	fixed_latency: assert property (@(posedge clock) disable iff (reset)
		start |=> !done [*32] ##1 done)
		else $error("divider done not 33 cycles after start");

endmodule

`default_nettype wire

// File: design/mds_sequencer.sv
//////////////////////////////
// request acceptance and engine dispatch
// result capture and out_valid pulse
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "mds_config.svh"

module mds_sequencer import mds_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  mds_req_t      req,
	input  logic          in_valid,
	output logic          ready,
	output word_t         result,
	output logic          out_valid,
	output mds_operands_t operands,
	output logic          shift_start,
	output mds_shift_e    shift_kind,
	input  logic          shift_done,
	input  word_t         shift_result,
	output logic          mul_start,
	output logic          mul_signed,
	output logic          mul_high,
	input  logic          mul_done,
	input  word_t         mul_result,
	output logic          div_start,
	output logic          div_rem,
	input  logic          div_done,
	input  word_t         div_result
);
	typedef enum logic [1:0] {IDLE, DISPATCH, WAIT} state_e;

	state_e     state;
	logic       sel_shift;
	logic       sel_mul;
	logic       sel_div;
	logic       is_shift;
	logic       is_mul;
	logic       is_div;
	mds_shift_e kind_d;
	logic       eng_done;
	word_t      eng_result;

	assign ready = (state == IDLE);

	always_comb begin
		is_shift = 1'b0;
		is_mul   = 1'b0;
		is_div   = 1'b0;
		kind_d   = SHIFT_LL;
		case (req.op)
			OP_SLL: is_shift = 1'b1;
			OP_SRL: begin
				is_shift = 1'b1;
				kind_d   = SHIFT_RL;
			end
			OP_SRA: begin
				is_shift = 1'b1;
				kind_d   = SHIFT_RA;
			end
			OP_MUL, OP_MULH, OP_MULS, OP_MULSH: is_mul = 1'b1;
			OP_DIV, OP_REM: is_div = 1'b1;
			default: is_shift = 1'b0;	// unknown op answers zero
		endcase
	end

	// selected engine, a disabled or missing one answers zero at once
	always_comb begin
		eng_done   = 1'b1;
		eng_result = '0;
		if (sel_shift) begin
			eng_done   = shift_done;
			eng_result = shift_result;
		end else if (sel_mul && (`MDS_ENABLE_MUL != 0)) begin
			eng_done   = mul_done;
			eng_result = mul_result;
		end else if (sel_div && (`MDS_ENABLE_DIV != 0)) begin
			eng_done   = div_done;
			eng_result = div_result;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= IDLE;
			result      <= '0;
			out_valid   <= 1'b0;
			shift_start <= 1'b0;
			mul_start   <= 1'b0;
			div_start   <= 1'b0;
			sel_shift   <= 1'b0;
			sel_mul     <= 1'b0;
			sel_div     <= 1'b0;
		end else begin
			out_valid   <= 1'b0;
			shift_start <= 1'b0;
			mul_start   <= 1'b0;
			div_start   <= 1'b0;
			case (state)
				IDLE: if (in_valid) begin
					state       <= DISPATCH;
					sel_shift   <= is_shift;
					sel_mul     <= is_mul;
					sel_div     <= is_div;
					shift_start <= is_shift;	// high during DISPATCH
					mul_start   <= is_mul && (`MDS_ENABLE_MUL != 0);
					div_start   <= is_div && (`MDS_ENABLE_DIV != 0);
				end
				DISPATCH: state <= WAIT;
				WAIT: begin
					if (out_valid) begin
						state <= IDLE;	// ready again after the pulse
					end else if (eng_done) begin
						result    <= eng_result;
						out_valid <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (ready && in_valid) begin
			operands   <= '{a: req.a, b: req.b};
			shift_kind <= kind_d;
			mul_signed <= (req.op == OP_MULS) || (req.op == OP_MULSH);
			mul_high   <= (req.op == OP_MULH) || (req.op == OP_MULSH);
			div_rem    <= (req.op == OP_REM);
		end
	end

	single_pulse: assert property (@(posedge clock) disable iff (reset)
		out_valid |=> !out_valid)
		else $error("out_valid high two cycles in a row");

	start_in_dispatch: assert property (@(posedge clock) disable iff (reset)
		(shift_start || mul_start || div_start) |-> (state == DISPATCH))
		else $error("engine start outside DISPATCH");

endmodule

`default_nettype wire

// File: design/mds_unit.sv
//////////////////////////////
// multiply/divide/shift unit top
// sequencer plus three engines
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mds_unit import mds_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  mds_req_t req,
	input  logic     in_valid,
	output logic     ready,
	output word_t    result,
	output logic     out_valid
);
	mds_operands_t operands;	// shared by all engines
	logic          shift_start;
	mds_shift_e    shift_kind;
	logic          shift_done;
	word_t         shift_result;
	logic          mul_start;
	logic          mul_signed;
	logic          mul_high;
	logic          mul_done;
	word_t         mul_result;
	logic          div_start;
	logic          div_rem;
	logic          div_done;
	word_t         div_result;

	mds_sequencer mds_sequencer_inst (
		.clock, .reset,
		.req, .in_valid, .ready,
		.result, .out_valid,
		.operands,
		.shift_start, .shift_kind, .shift_done, .shift_result,
		.mul_start, .mul_signed, .mul_high, .mul_done, .mul_result,
		.div_start, .div_rem, .div_done, .div_result
	);

	mds_shifter mds_shifter_inst (
		.clock, .reset,
		.start    (shift_start),
		.kind     (shift_kind),
		.operands,
		.done     (shift_done),
		.result   (shift_result)
	);

	// a disabled engine never sees start and is trimmed by synthesis
	mds_multiplier mds_multiplier_inst (
		.clock, .reset,
		.start      (mul_start),
		.signed_ops (mul_signed),
		.high_word  (mul_high),
		.operands,
		.done       (mul_done),
		.result     (mul_result)
	);

	mds_divider mds_divider_inst (
		.clock, .reset,
		.start    (div_start),
		.want_rem (div_rem),
		.operands,
		.done     (div_done),
		.result   (div_result)
	);

endmodule

`default_nettype wire

// File: sim/mds_tb.sv
//////////////////////////////
// testbench for the mds unit
// seeded random ops, model, monitor
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none
`include "mds_config.svh"

module mds_tb import mds_pkg::*; ();

	logic     clock = 1'b0;
	logic     reset;
	mds_req_t req;
	logic     in_valid;
	logic     ready;
	word_t    result;
	logic     out_valid;
	integer   seed = 32'h933c;
	logic     prev_valid;	// monitor state
	word_t    last_result;

	mds_unit mds_unit_inst (
		.clock, .reset,
		.req, .in_valid, .ready,
		.result, .out_valid
	);

	always #5 clock = ~clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopping after the first error");
	endtask

	task automatic check(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			abort_run("value mismatch");
		end
	endtask

	// reference model, straight from the op definitions
	function automatic word_t expected_result(input mds_op_e op, input word_t a, input word_t b);
		logic [4:0]         sh;
		logic [63:0]        uprod;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] sprod;
		logic signed [63:0] quot;
		logic signed [63:0] remd;
		sh    = b[4:0];
		sa    = $signed(a);	// sign extended to 64 bits
		sb    = $signed(b);
		uprod = {32'b0, a} * {32'b0, b};
		sprod = sa * sb;
		case (op)
			OP_SLL: return a << sh;
			OP_SRL: return a >> sh;
			OP_SRA: return word_t'(sa >>> sh);
			OP_MUL, OP_MULH, OP_MULS, OP_MULSH: begin
				if (`MDS_ENABLE_MUL == 0)
					return '0;
				case (op)
					OP_MUL:  return uprod[31:0];
					OP_MULH: return uprod[63:32];
					OP_MULS: return sprod[31:0];
					default: return sprod[63:32];
				endcase
			end
			OP_DIV, OP_REM: begin
				if (`MDS_ENABLE_DIV == 0)
					return '0;
				if (b == '0)
					return (op == OP_REM) ? a : '1;
				if ((a == 32'h8000_0000) && (b == '1))
					return (op == OP_REM) ? '0 : 32'h8000_0000;
				quot = sa / sb;	// truncates toward zero
				remd = sa % sb;	// sign of the dividend
				return (op == OP_REM) ? remd[31:0] : quot[31:0];
			end
			default: return '0;
		endcase
	endfunction

	// edge values more often than plain random words
	function automatic word_t rand_operand();
		int unsigned pick;
		pick = $unsigned($random(seed)) % 8;
		case (pick)
			0: return '0;
			1: return '1;
			2: return 32'h8000_0000;
			3: return $unsigned($random(seed)) % 32;
			4: return 32'h7fff_ffff;
			default: return $random(seed);
		endcase
	endfunction

	function automatic logic [4:0] rand_shamt();
		int unsigned pick;
		pick = $unsigned($random(seed)) % 4;
		case (pick)
			0: return 5'd0;
			1: return 5'd31;
			default: return $unsigned($random(seed)) % 32;
		endcase
	endfunction

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!ready) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > 100)
				abort_run("timeout waiting for ready");
		end
	endtask

	task automatic wait_result(output word_t value);
		int cycles;
		cycles = 0;
		while (!out_valid) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > 100)
				abort_run("timeout waiting for out_valid");
		end
		value = result;
	endtask

	task automatic drive_req(input mds_op_e op, input word_t a, input word_t b);
		req.op   = op;
		req.a    = a;
		req.b    = b;
		in_valid = 1'b1;
	endtask

	// one request from handshake to checked result
	task automatic run_op(input string name, input mds_op_e op, input word_t a, input word_t b);
		word_t expected;
		word_t got;
		expected = expected_result(op, a, b);
		wait_ready();
		drive_req(op, a, b);
		@(posedge clock);
		#1;
		in_valid = 1'b0;	// taken on that edge
		wait_result(got);
		check(name, expected, got);
	endtask

	// pulse width and result hold, sampled away from the active edge
	always @(negedge clock) begin
		if (reset) begin
			prev_valid  = 1'b0;
			last_result = '0;
		end else begin
			check("out_valid single cycle", '0, prev_valid && out_valid);
			if (!out_valid)
				check("result held between pulses", last_result, result);
			prev_valid  = out_valid;
			last_result = result;
		end
	end

	initial begin
		int      i;
		word_t   a;
		word_t   b;
		word_t   first_exp;
		word_t   second_exp;
		word_t   got;
		int      cycles;
		mds_op_e op;
		reset    = 1'b1;
		in_valid = 1'b0;
		req      = '0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		check("ready after reset", 32'd1, ready);
		check("out_valid after reset", '0, out_valid);
		repeat (10) begin
			@(posedge clock);
			#1;
			check("no out_valid while idle", '0, out_valid);
		end

		run_op("sll count 31", OP_SLL, 32'h0000_0001, 32'd31);
		run_op("srl count 0", OP_SRL, 32'hdead_beef, 32'd0);
		run_op("sra negative", OP_SRA, 32'h8000_0000, 32'd31);
		for (i = 0; i < 200; i++) begin
			a = rand_operand();
			b = {$random(seed)} & 32'hffff_ffe0;
			b[4:0] = rand_shamt();
			case ($unsigned($random(seed)) % 3)
				0: op = OP_SLL;
				1: op = OP_SRL;
				default: op = OP_SRA;
			endcase
			run_op($sformatf("shift %0d", i), op, a, b);
		end

		for (i = 0; i < 200; i++) begin
			a = rand_operand();
			b = rand_operand();
			case ($unsigned($random(seed)) % 4)
				0: op = OP_MUL;
				1: op = OP_MULH;
				2: op = OP_MULS;
				default: op = OP_MULSH;
			endcase
			run_op($sformatf("multiply %0d", i), op, a, b);
		end

		run_op("div overflow", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
		run_op("rem overflow", OP_REM, 32'h8000_0000, 32'hffff_ffff);
		run_op("div by zero", OP_DIV, 32'h1234_5678, 32'd0);
		run_op("rem by zero", OP_REM, 32'hfedc_ba98, 32'd0);
		for (i = 0; i < 200; i++) begin
			a  = rand_operand();
			b  = rand_operand();
			op = ($unsigned($random(seed)) % 2 == 0) ? OP_DIV : OP_REM;
			run_op($sformatf("divide %0d", i), op, a, b);
		end

		// second request held on the bus while the first is in flight
		first_exp  = expected_result(OP_DIV, -32'sd100, 32'd7);
		second_exp = expected_result(OP_SLL, 32'd5, 32'd3);
		wait_ready();
		drive_req(OP_DIV, -32'sd100, 32'd7);
		@(posedge clock);
		#1;
		drive_req(OP_SLL, 32'd5, 32'd3);
		cycles = 0;
		while (!out_valid) begin
			check("ready low while busy", '0, ready);
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > 100)
				abort_run("timeout waiting for the first result under back-pressure");
		end
		check("first result under back-pressure", first_exp, result);
		check("ready low in pulse cycle", '0, ready);
		@(posedge clock);
		#1;
		check("single pulse for first request", '0, out_valid);
		check("ready after pulse", 32'd1, ready);
		@(posedge clock);
		#1;
		check("held request accepted", '0, ready);
		in_valid = 1'b0;
		wait_result(got);
		check("held request result", second_exp, got);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
design/mds_pkg.sv
design/mds_shifter.sv
design/mds_multiplier.sv
design/mds_divider.sv
design/mds_sequencer.sv
design/mds_unit.sv
sim/mds_tb.sv

// File: Bender.yml
package:
  name: mds_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/mds_pkg.sv
      - design/mds_shifter.sv
      - design/mds_multiplier.sv
      - design/mds_divider.sv
      - design/mds_sequencer.sv
      - design/mds_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/mds_tb.sv
